// ==== include/cs_params.svh ====
`ifndef CS_PARAMS_SVH
`define CS_PARAMS_SVH

// image dimension in pixels
`define CS_DIM_W 16

// byte address on the DMA side
`define CS_ADDR_W 32

// tile index, enough for 65528/8 tiles
`define CS_TILE_IDX_W 13

// row inside one tile
`define CS_ROW_IDX_W 3

`define CS_TILE_PIX 8

`define CS_PIX_BYTES 3

// one tile row, moved as a single fixed burst
`define CS_TILE_ROW_BYTES 24

`define CS_SRC_ALIGN 4

`endif

// ==== source/cs_pkg.sv ====
`default_nettype none

`include "cs_params.svh"

package cs_pkg;

	typedef enum logic [1:0] {
		CS_IDLE  = 2'd0,
		CS_READ  = 2'd1,
		CS_WRITE = 2'd2
	} cs_state_e;

	// clockwise rotation
	typedef enum logic [1:0] {
		ROT_0   = 2'd0,
		ROT_90  = 2'd1,
		ROT_180 = 2'd2,
		ROT_270 = 2'd3
	} cs_rot_e;

	typedef struct packed {
		logic [`CS_DIM_W-1:0]      new_height;
		logic [`CS_DIM_W-1:0]      new_width;
		logic [`CS_ADDR_W-1:0]     src_pitch;
		logic [`CS_ADDR_W-1:0]     dst_pitch;
		logic [`CS_ADDR_W-1:0]     dst_base;
		logic [`CS_TILE_IDX_W-1:0] tiles_h;
		logic [`CS_TILE_IDX_W-1:0] tiles_w;
		logic [`CS_DIM_W-1:0]      src_height;
		logic [`CS_DIM_W-1:0]      src_width;
		cs_rot_e                   rot;       // after direction swap
	} cs_geom_t;

	typedef struct packed {
		cs_state_e                 state;
		logic [`CS_TILE_IDX_W-1:0] tile_y;
		logic [`CS_TILE_IDX_W-1:0] tile_x;
		logic [`CS_ROW_IDX_W-1:0]  row;
	} cs_pos_t;

	typedef struct packed {
		logic       row_pad;   // row below source height
		logic [3:0] valid_pix; // 0..8 real pixels
	} cs_pad_t;

endpackage

`default_nettype wire

// ==== source/cs_geometry.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cs_params.svh"

module cs_geometry (
	input  logic                  I_CS_HCLK,
	input  logic                  I_CS_HRESET_N,
	input  logic                  start,
	input  logic [`CS_DIM_W-1:0]  height,
	input  logic [`CS_DIM_W-1:0]  width,
	input  cs_pkg::cs_rot_e       degrees,
	input  logic                  direction,
	output cs_pkg::cs_geom_t      geom,
	input  logic                  busy
);

	import cs_pkg::*;

	localparam logic [`CS_DIM_W-1:0]  PAD_MASK   = `CS_DIM_W'(`CS_TILE_PIX - 1);
	localparam logic [`CS_ADDR_W-1:0] ALIGN_MASK = `CS_ADDR_W'(`CS_SRC_ALIGN - 1);

	logic [`CS_DIM_W-1:0]  pad_h;
	logic [`CS_DIM_W-1:0]  pad_w;
	logic [`CS_DIM_W-1:0]  new_h;
	logic [`CS_DIM_W-1:0]  new_w;
	logic [`CS_ADDR_W-1:0] src_row_bytes;
	cs_rot_e               rot_eff;
	cs_geom_t              geom_nxt;

	// inputs are limited to 65528, so the sum cannot overflow
	assign pad_h = (height + PAD_MASK) & ~PAD_MASK;
	assign pad_w = (width + PAD_MASK) & ~PAD_MASK;

	always_comb begin
		case (degrees)
			ROT_90:  rot_eff = direction ? ROT_90 : ROT_270;
			ROT_270: rot_eff = direction ? ROT_270 : ROT_90;
			default: rot_eff = degrees;
		endcase
	end

	// quarter turns swap the sides
	assign new_h = rot_eff[0] ? pad_w : pad_h;
	assign new_w = rot_eff[0] ? pad_h : pad_w;

	assign src_row_bytes = `CS_ADDR_W'(width) * `CS_PIX_BYTES;

	always_comb begin
		geom_nxt            = '0;
		geom_nxt.new_height = new_h;
		geom_nxt.new_width  = new_w;
		geom_nxt.src_pitch  = (src_row_bytes + ALIGN_MASK) & ~ALIGN_MASK;
		geom_nxt.dst_pitch  = `CS_ADDR_W'(new_w) * `CS_PIX_BYTES;
		geom_nxt.dst_base   = `CS_ADDR_W'(new_h) * `CS_ADDR_W'(new_w) * `CS_PIX_BYTES;
		geom_nxt.tiles_h    = `CS_TILE_IDX_W'(pad_h / `CS_TILE_PIX);
		geom_nxt.tiles_w    = `CS_TILE_IDX_W'(pad_w / `CS_TILE_PIX);
		geom_nxt.src_height = height;
		geom_nxt.src_width  = width;
		geom_nxt.rot        = rot_eff;
	end

	always_ff @(posedge I_CS_HCLK) begin
		if (!I_CS_HRESET_N) begin
			geom <= '0;
		end else if (start && !busy) begin
			geom <= geom_nxt; // held for the whole job
		end
	end

endmodule

`default_nettype wire

// ==== source/cs_tile_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cs_params.svh"

module cs_tile_sequencer (
	input  logic             I_CS_HCLK,
	input  logic             I_CS_HRESET_N,
	input  logic             start,
	input  logic             dma_ready,
	input  cs_pkg::cs_geom_t geom,
	output cs_pkg::cs_pos_t  pos,
	output logic             busy,
	output logic             write,
	output logic             done
);

	import cs_pkg::*;

	cs_state_e                 state;
	cs_state_e                 state_nxt;
	logic [`CS_ROW_IDX_W-1:0]  row;
	logic [`CS_TILE_IDX_W-1:0] tile_y;
	logic [`CS_TILE_IDX_W-1:0] tile_x;
	logic                      start_ok;
	logic                      step;
	logic                      row_last;
	logic                      ty_last;
	logic                      tx_last;
	logic                      tile_end;

	assign busy     = (state != CS_IDLE);
	assign start_ok = start && !busy;
	assign step     = dma_ready && busy;  // transfer accepted this cycle

	assign row_last = (row == `CS_ROW_IDX_W'(`CS_TILE_PIX - 1));
	assign ty_last  = (tile_y == geom.tiles_h - `CS_TILE_IDX_W'(1));
	assign tx_last  = (tile_x == geom.tiles_w - `CS_TILE_IDX_W'(1));
	assign tile_end = step && row_last && (state == CS_WRITE);

	always_comb begin
		state_nxt = state;
		case (state)
			CS_IDLE: begin
				if (start_ok)
					state_nxt = CS_READ;
			end
			CS_READ: begin
				if (step && row_last)
					state_nxt = CS_WRITE; // same tile, write side
			end
			CS_WRITE: begin
				if (step && row_last)
					state_nxt = (ty_last && tx_last) ? CS_IDLE : CS_READ;
			end
			default: state_nxt = CS_IDLE;
		endcase
	end

	always_ff @(posedge I_CS_HCLK) begin
		if (!I_CS_HRESET_N) begin
			state  <= CS_IDLE;
			row    <= '0;
			tile_y <= '0;
			tile_x <= '0;
			write  <= 1'b0;
			done   <= 1'b0;
		end else begin
			state <= state_nxt;
			write <= (state_nxt == CS_WRITE);
			if (start_ok) begin
				row    <= '0;
				tile_y <= '0;
				tile_x <= '0;
				done   <= 1'b0; // new job clears it
			end else if (step) begin
				row <= row_last ? '0 : row + `CS_ROW_IDX_W'(1);
				if (tile_end) begin
					// tile row index runs inside, column outside
					if (!ty_last) begin
						tile_y <= tile_y + `CS_TILE_IDX_W'(1);
					end else begin
						tile_y <= '0;
						if (tx_last) begin
							tile_x <= '0;
							done   <= 1'b1;
						end else begin
							tile_x <= tile_x + `CS_TILE_IDX_W'(1);
						end
					end
				end
			end
		end
	end

	always_comb begin
		pos        = '0;
		pos.state  = state;
		pos.tile_y = tile_y;
		pos.tile_x = tile_x;
		pos.row    = row;
	end

endmodule

`default_nettype wire

// ==== source/cs_src_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cs_params.svh"

module cs_src_addr (
	input  cs_pkg::cs_geom_t       geom,
	input  cs_pkg::cs_pos_t        pos,
	output logic [`CS_ADDR_W-1:0]  src_addr,
	output cs_pkg::cs_pad_t        pad
);

	import cs_pkg::*;

	logic [`CS_DIM_W-1:0] row_abs;
	logic [`CS_DIM_W-1:0] col_abs;
	logic [`CS_DIM_W-1:0] pix_left;
	logic                 below_src;

	// 8*ty + r and 8*tx, tile edge is a power of two
	assign row_abs = {pos.tile_y, pos.row};
	assign col_abs = {pos.tile_x, `CS_ROW_IDX_W'(0)};

	assign src_addr = `CS_ADDR_W'(row_abs) * geom.src_pitch
		+ `CS_ADDR_W'(pos.tile_x) * `CS_TILE_ROW_BYTES;

	assign below_src = (row_abs >= geom.src_height);
	assign pix_left  = geom.src_width - col_abs;

	always_comb begin
		pad = '0;
		if (pos.state == CS_READ) begin
			pad.row_pad = below_src;
			if (!below_src) begin
				if (pix_left >= `CS_DIM_W'(`CS_TILE_PIX))
					pad.valid_pix = 4'(`CS_TILE_PIX);
				else
					pad.valid_pix = pix_left[3:0]; // right edge tile
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/cs_addr_out.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cs_params.svh"

module cs_addr_out (
	input  cs_pkg::cs_geom_t       geom,
	input  cs_pkg::cs_pos_t        pos,
	input  logic [`CS_ADDR_W-1:0]  src_addr,
	output logic [`CS_ADDR_W-1:0]  addr
);

	import cs_pkg::*;

	logic [`CS_TILE_IDX_W-1:0] ty_rev;
	logic [`CS_TILE_IDX_W-1:0] tx_rev;
	logic [`CS_TILE_IDX_W-1:0] dy;
	logic [`CS_TILE_IDX_W-1:0] dx;
	logic [`CS_DIM_W-1:0]      dst_row;
	logic [`CS_ADDR_W-1:0]     dst_addr;

	assign ty_rev = geom.tiles_h - `CS_TILE_IDX_W'(1) - pos.tile_y;
	assign tx_rev = geom.tiles_w - `CS_TILE_IDX_W'(1) - pos.tile_x;

	always_comb begin
		case (geom.rot)
			ROT_90: begin
				dy = pos.tile_x;
				dx = ty_rev;
			end
			ROT_180: begin
				dy = ty_rev;
				dx = tx_rev;
			end
			ROT_270: begin
				dy = tx_rev;
				dx = pos.tile_y;
			end
			default: begin
				dy = pos.tile_y;
				dx = pos.tile_x;
			end
		endcase
	end

	// pixel order inside the tile is left to the image memory
	assign dst_row = {dy, pos.row};

	assign dst_addr = geom.dst_base
		+ `CS_ADDR_W'(dst_row) * geom.dst_pitch
		+ `CS_ADDR_W'(dx) * `CS_TILE_ROW_BYTES;

	always_comb begin
		case (pos.state)
			CS_READ:  addr = src_addr;
			CS_WRITE: addr = dst_addr;
			default:  addr = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/core_set.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cs_params.svh"

module core_set (
	input  logic                  I_CS_HCLK,
	input  logic                  I_CS_HRESET_N,
	input  logic                  I_CS_START,
	input  logic [`CS_DIM_W-1:0]  I_CS_HEIGHT,
	input  logic [`CS_DIM_W-1:0]  I_CS_WIDTH,
	input  cs_pkg::cs_rot_e       I_CS_DEGREES,
	input  logic                  I_CS_DIRECTION,
	input  logic                  I_CS_DMA_READY,
	output logic [`CS_ADDR_W-1:0] O_CS_ADDR,      // to dma
	output logic                  O_CS_WRITE,     // to dma
	output cs_pkg::cs_pad_t       O_CS_IMEM_PAD,  // to imem
	output logic [`CS_ADDR_W-1:0] O_CS_DST_IMG,   // to register file
	output logic [`CS_DIM_W-1:0]  O_CS_NEW_H,
	output logic [`CS_DIM_W-1:0]  O_CS_NEW_W,
	output logic                  O_CS_INTR_DONE
);

	import cs_pkg::*;

	cs_geom_t              geom;
	cs_pos_t               pos;
	logic                  busy;
	logic [`CS_ADDR_W-1:0] src_addr;

	cs_geometry u_geometry (
		.I_CS_HCLK     (I_CS_HCLK),
		.I_CS_HRESET_N (I_CS_HRESET_N),
		.start         (I_CS_START),
		.height        (I_CS_HEIGHT),
		.width         (I_CS_WIDTH),
		.degrees       (I_CS_DEGREES),
		.direction     (I_CS_DIRECTION),
		.geom          (geom),
		.busy          (busy)
	);

	cs_tile_sequencer u_sequencer (
		.I_CS_HCLK     (I_CS_HCLK),
		.I_CS_HRESET_N (I_CS_HRESET_N),
		.start         (I_CS_START),
		.dma_ready     (I_CS_DMA_READY),
		.geom          (geom),
		.pos           (pos),
		.busy          (busy),
		.write         (O_CS_WRITE),
		.done          (O_CS_INTR_DONE)
	);

	cs_src_addr u_src_addr (
		.geom     (geom),
		.pos      (pos),
		.src_addr (src_addr),
		.pad      (O_CS_IMEM_PAD)
	);

	cs_addr_out u_addr_out (
		.geom     (geom),
		.pos      (pos),
		.src_addr (src_addr),
		.addr     (O_CS_ADDR)
	);

	assign O_CS_NEW_H   = geom.new_height;
	assign O_CS_NEW_W   = geom.new_width;
	assign O_CS_DST_IMG = geom.dst_base;

endmodule

`default_nettype wire

// ==== tests/tb_core_set.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cs_params.svh"

module tb_core_set;

	import cs_pkg::*;

	localparam int TIMEOUT_CYC = 20000;

	logic                  clk;
	logic                  rst_n;
	logic                  start;
	logic [`CS_DIM_W-1:0]  height;
	logic [`CS_DIM_W-1:0]  width;
	cs_rot_e               degrees;
	logic                  direction;
	logic                  ready;
	logic [`CS_ADDR_W-1:0] addr;
	logic                  write;
	cs_pad_t               pad;
	logic [`CS_ADDR_W-1:0] dst_img;
	logic [`CS_DIM_W-1:0]  new_h;
	logic [`CS_DIM_W-1:0]  new_w;
	logic                  done;

	int          errors;
	int          checks;
	int          tests;
	int          failed_tests;
	int          err_mark;
	bit          active;     // model of the busy job
	int          xfer_idx;
	int          xfer_total;
	int          job_h;
	int          job_w;
	cs_rot_e     job_deg;
	logic        job_dir;
	int unsigned seed;
	int          sizes_h [4] = '{8, 16, 13, 1};
	int          sizes_w [4] = '{8, 24, 5, 30};

	core_set u_core_set (
		.I_CS_HCLK      (clk),
		.I_CS_HRESET_N  (rst_n),
		.I_CS_START     (start),
		.I_CS_HEIGHT    (height),
		.I_CS_WIDTH     (width),
		.I_CS_DEGREES   (degrees),
		.I_CS_DIRECTION (direction),
		.I_CS_DMA_READY (ready),
		.O_CS_ADDR      (addr),
		.O_CS_WRITE     (write),
		.O_CS_IMEM_PAD  (pad),
		.O_CS_DST_IMG   (dst_img),
		.O_CS_NEW_H     (new_h),
		.O_CS_NEW_W     (new_w),
		.O_CS_INTR_DONE (done)
	);

	always #20 clk = ~clk;

	function automatic int pad8(input int x);
		return (x + 7) / 8 * 8;
	endfunction

	function automatic cs_rot_e eff_rot(input cs_rot_e deg, input logic dir);
		if (!dir && deg == ROT_90)
			return ROT_270;
		if (!dir && deg == ROT_270)
			return ROT_90;
		return deg;
	endfunction

	function automatic logic [15:0] ref_dim(input int h, input int w, input cs_rot_e deg,
		input logic dir, input bit want_w);
		bit quarter;
		quarter = (eff_rot(deg, dir) == ROT_90) || (eff_rot(deg, dir) == ROT_270);
		if (quarter ^ want_w)
			return 16'(pad8(w));
		return 16'(pad8(h));
	endfunction

	// int arithmetic wraps like the 32-bit address
	function automatic logic [31:0] ref_base(input int h, input int w, input cs_rot_e deg,
		input logic dir);
		return 32'(3 * int'(ref_dim(h, w, deg, dir, 1'b0)) * int'(ref_dim(h, w, deg, dir, 1'b1)));
	endfunction

	function automatic logic [31:0] ref_addr(input int h, input int w, input cs_rot_e deg,
		input logic dir, input int ty, input int tx, input int r, input bit wr);
		int th;
		int tw;
		int dy;
		int dx;
		int pitch;
		th = pad8(h) / 8;
		tw = pad8(w) / 8;
		if (!wr)
			return 32'((8 * ty + r) * ((3 * w + 3) / 4 * 4) + 24 * tx);
		dy = ty;
		dx = tx;
		case (eff_rot(deg, dir))
			ROT_90: begin
				dy = tx;
				dx = th - 1 - ty;
			end
			ROT_180: begin
				dy = th - 1 - ty;
				dx = tw - 1 - tx;
			end
			ROT_270: begin
				dy = tw - 1 - tx;
				dx = ty;
			end
			default: ;
		endcase
		pitch = 3 * int'(ref_dim(h, w, deg, dir, 1'b1));
		return 32'(int'(ref_base(h, w, deg, dir)) + (8 * dy + r) * pitch + 24 * dx);
	endfunction

	function automatic cs_pad_t ref_pad(input int h, input int w, input int ty, input int tx,
		input int r, input bit wr);
		cs_pad_t p;
		int left;
		p = '0;
		left = w - 8 * tx;
		if (!wr) begin
			p.row_pad = (8 * ty + r >= h);
			if (!p.row_pad)
				p.valid_pix = 4'((left > 8) ? 8 : left);
		end
		return p;
	endfunction

	task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_pad(input string name, input cs_pad_t got, input cs_pad_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_dim(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%04h, expected 0x%04h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// one accepted transfer per rising edge with ready high
	always @(posedge clk) begin : compare
		bit was_active;
		bit wr;
		int tile;
		int ty;
		int tx;
		int r;
		was_active = active;
		if (was_active && ready) begin
			tile = xfer_idx / 16;
			wr = (xfer_idx % 16) >= 8;
			r = xfer_idx % 8;
			ty = tile % (pad8(job_h) / 8); // tile row index inside
			tx = tile / (pad8(job_h) / 8);
			check_addr("O_CS_ADDR", addr, ref_addr(job_h, job_w, job_deg, job_dir, ty, tx, r, wr));
			check_pad("O_CS_IMEM_PAD", pad, ref_pad(job_h, job_w, ty, tx, r, wr));
			check_flag("O_CS_WRITE", write, wr);
			check_flag("O_CS_INTR_DONE", done, 1'b0);
			xfer_idx++;
			if (xfer_idx == xfer_total)
				active = 1'b0;
		end
		if (start && !was_active && rst_n) begin
			job_h = int'(height);
			job_w = int'(width);
			job_deg = degrees;
			job_dir = direction;
			xfer_idx = 0;
			xfer_total = 16 * (pad8(job_h) / 8) * (pad8(job_w) / 8);
			active = 1'b1;
		end
	end

	task automatic run_job(input int h, input int w, input cs_rot_e deg, input logic dir,
		input bit rand_ready, input int poke_at);
		int cyc;
		@(negedge clk);
		height = 16'(h);
		width = 16'(w);
		degrees = deg;
		direction = dir;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_dim("O_CS_NEW_H", new_h, ref_dim(h, w, deg, dir, 1'b0));
		check_dim("O_CS_NEW_W", new_w, ref_dim(h, w, deg, dir, 1'b1));
		check_addr("O_CS_DST_IMG", dst_img, ref_base(h, w, deg, dir));
		check_flag("O_CS_INTR_DONE", done, 1'b0);
		cyc = 0;
		while (!done) begin
			if (cyc == TIMEOUT_CYC) begin
				$display("job %0dx%0d did not finish within %0d cycles", h, w, TIMEOUT_CYC);
				$display("TEST FAIL");
				$finish;
			end
			if (!active)
				check_flag("O_CS_INTR_DONE", done, 1'b1); // last transfer already taken
			ready = rand_ready ? ($urandom % 3 != 0) : 1'b1;
			start = (cyc == poke_at);  // stray start while busy
			height = (cyc == poke_at) ? 16'(h + 8) : 16'(h);
			@(negedge clk);
			cyc++;
		end
		ready = 1'b0;
		checks++;
		if (active || xfer_idx != xfer_total) begin
			errors++;
			$display("job %0dx%0d ended after %0d transfers, expected %0d", h, w, xfer_idx,
				xfer_total);
		end
		check_addr("O_CS_ADDR", addr, 32'h0);
		check_flag("O_CS_WRITE", write, 1'b0);
		check_pad("O_CS_IMEM_PAD", pad, '0);
		check_dim("O_CS_NEW_H", new_h, ref_dim(h, w, deg, dir, 1'b0));
		check_addr("O_CS_DST_IMG", dst_img, ref_base(h, w, deg, dir));
	endtask

	task automatic hold_done(input int cycles);
		repeat (cycles) begin
			ready = 1'($urandom % 2);
			@(negedge clk);
			check_flag("O_CS_INTR_DONE", done, 1'b1);
			check_addr("O_CS_ADDR", addr, 32'h0);
		end
		ready = 1'b0;
	endtask

	task automatic report_test(input string name);
		string verdict;
		tests++;
		verdict = "ok";
		if (errors != err_mark) begin
			failed_tests++;
			verdict = "failed";
		end
		$display("test %0d %s: %s, %0d errors", tests, name, verdict, errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		seed = $urandom(68342);
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		height = '0;
		width = '0;
		degrees = ROT_0;
		direction = 1'b0;
		ready = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		err_mark = 0;
		active = 1'b0;
		xfer_idx = 0;
		xfer_total = 0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		check_flag("O_CS_WRITE", write, 1'b0);
		check_flag("O_CS_INTR_DONE", done, 1'b0);
		check_dim("O_CS_NEW_H", new_h, 16'h0);
		check_dim("O_CS_NEW_W", new_w, 16'h0);
		check_addr("O_CS_DST_IMG", dst_img, 32'h0);
		check_addr("O_CS_ADDR", addr, 32'h0);
		report_test("reset values");

		for (int i = 0; i < 4; i++)
			for (int d = 0; d < 4; d++)
				for (int dir = 0; dir < 2; dir++)
					run_job(sizes_h[i], sizes_w[i], cs_rot_e'(d), 1'(dir), 1'b0, -1);
		report_test("geometry and padding");

		run_job(21, 19, ROT_0, 1'b1, 1'b0, -1);  // bottom and right edge tiles
		run_job(5, 30, ROT_180, 1'b1, 1'b0, -1);
		report_test("read addresses and pad");

		for (int d = 0; d < 4; d++)
			for (int dir = 0; dir < 2; dir++)
				run_job(20, 35, cs_rot_e'(d), 1'(dir), 1'b0, -1);
		report_test("rotated writes");

		for (int i = 0; i < 6; i++) begin
			run_job(int'(1 + $urandom % 40), int'(1 + $urandom % 40), cs_rot_e'($urandom % 4),
				1'($urandom % 2), 1'b1, -1);
			hold_done(int'(3 + $urandom % 5));
		end
		report_test("random back-pressure");

		run_job(17, 26, ROT_90, 1'b0, 1'b1, 5);
		run_job(9, 9, ROT_270, 1'b1, 1'b0, 40);
		report_test("start while busy");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks,
			errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
source/cs_pkg.sv
source/cs_geometry.sv
source/cs_tile_sequencer.sv
source/cs_src_addr.sv
source/cs_addr_out.sv
source/core_set.sv
tests/tb_core_set.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core_set testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
	--top-module tb_core_set \
	-f src.f
./obj_dir/Vtb_core_set > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
